// File: sim.f
verilog/sortPkg.sv
verilog/oddEvenStage.sv
verilog/blockLoader.sv
verilog/blockWriter.sv
verilog/plbMasterEngine.sv
verilog/bramMailbox.sv
verilog/sortTester.sv
bench/plbBramModel.sv
bench/sortTesterTb.sv

// File: run.sh
#!/bin/sh
# build and run the sort tester simulation with Verilator
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert -j 0 --top-module sortTesterTb -f sim.f -o sortTesterSim
# a fatal stop exits non-zero, the log decides the result
./obj_dir/sortTesterSim > sim.log 2>&1 || true
cat sim.log
if grep -q "Test failures found" sim.log || ! grep -q "All tests passed!" sim.log; then
  echo "simulation FAILED"
  exit 1
fi
echo "simulation ok"

// File: bench/sortTesterTb.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// sort tester testbench
// mailbox jobs against the plb memory model
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/100ps

module sortTesterTb;

  localparam int BlockSize   = 8;
  // blocks over all jobs issued below
  localparam int TotalBlocks = 18;
  // one read and one write per word at 12 cycles each plus slack
  localparam int CycleLimit  = TotalBlocks * BlockSize * 2 * 12 + 2000;

  logic                              CLK = 1'b0;
  logic                              arstN;
  logic                              hostWe;
  logic [sortPkg::bramAddrWidth-1:0] hostAddr;
  logic [31:0]                       hostData;
  logic                              slowWrites;
  logic                              cmdSent;
  int                                cycleCount = 0;
  int                                errorCount = 0;
  int                                jobsDone;

  logic [sortPkg::addrWidth-1:0]     mABus;
  logic [sortPkg::dataWidth/8-1:0]   mBE;
  logic                              mRNW;
  logic                              mRequest;
  logic [sortPkg::dataWidth-1:0]     mWrDBus;
  // abort, lock, compress, guarded, lockErr, mSize, ordered, priority,
  // rdBurst, size, type and wrBurst from bit 0 up
  wire  [18:0]                       tieOffs;
  logic                              mAddrAck;
  logic                              mBusy;
  logic                              mErr;
  logic                              mRdDAck;
  logic [sortPkg::dataWidth-1:0]     mRdDBus;
  logic                              mWrDAck;
  logic [sortPkg::addrWidth-1:0]     bramAddr;
  logic [31:0]                       bramDout;
  logic [3:0]                        bramWEN;
  logic                              bramEN;
  logic                              bramCLK;
  logic                              bramRST;
  logic [31:0]                       bramDin;

  sortTester #(.BlockSize(BlockSize)) sortTester_inst (
    .CLK, .arstN,
    .mABus, .mBE, .mRNW, .mAbort(tieOffs[0]), .mBusLock(tieOffs[1]),
    .mCompress(tieOffs[2]), .mGuarded(tieOffs[3]), .mLockErr(tieOffs[4]),
    .mMSize(tieOffs[6:5]), .mOrdered(tieOffs[7]), .mPriority(tieOffs[9:8]),
    .mRdBurst(tieOffs[10]), .mRequest, .mSize(tieOffs[14:11]),
    .mType(tieOffs[17:15]), .mWrBurst(tieOffs[18]), .mWrDBus,
    .mAddrAck, .mBusy, .mErr, .mRdDAck, .mRdDBus, .mWrDAck,
    .bramAddr, .bramDout, .bramWEN, .bramEN, .bramCLK, .bramRST, .bramDin
  );

  plbBramModel plbBramModel_inst (
    .CLK, .mRequest, .mRNW, .mABus, .mWrDBus, .slowWrites,
    .mAddrAck, .mRdDAck, .mWrDAck, .mRdDBus, .mBusy, .mErr,
    .bramCLK, .bramRST, .bramEN, .bramWEN, .bramAddr, .bramDout, .bramDin,
    .hostWe, .hostAddr, .hostData
  );

  always #2 CLK = ~CLK;

  always @(posedge CLK) begin
    cycleCount <= cycleCount + 1;
    if (cycleCount >= CycleLimit) begin
      $display("Timeout: jobs still unfinished after %0d cycles", CycleLimit);
      $display("Test failures found");
      $fatal(1, "run ended by the cycle limit");
    end
  end

  task automatic failNow(input string msg);
    errorCount++;
    $display("FAIL at %0t ns: %s", $time, msg);
    $display("Test failures found");
    $fatal(1, "stopped at the first error");
  endtask

  // bus and mailbox port quiet while reset is held
  assert property (@(posedge CLK) (!arstN && cycleCount > 0) |->
                   (!mRequest && !bramEN && bramWEN == 4'h0))
    else failNow("bus request or mailbox access during reset");

  // only polling reads before the first command
  assert property (@(posedge CLK) (arstN && !cmdSent) |-> (!mRequest && bramWEN == 4'h0))
    else failNow("bus request or mailbox write before the first command");

  // tied-off plb controls and full byte enables on every transfer
  assert property (@(posedge CLK) disable iff (!arstN)
                   tieOffs == '0 && (!mRequest || mBE == '1))
    else failNow($sformatf("tie-offs %h or byte enables %h wrong", tieOffs, mBE));

  function automatic logic [sortPkg::dataWidth-1:0] memWord(input int w);
    return plbBramModel_inst.mem[10'(w)];
  endfunction

  task automatic hostWrite(input logic [sortPkg::bramAddrWidth-1:0] addr,
                           input logic [31:0] data);
    @(posedge CLK);
    #1;
    hostWe   = 1'b1;
    hostAddr = addr;
    hostData = data;
    @(posedge CLK);
    #1;
    hostWe = 1'b0;
  endtask

  // word indices in, byte addresses to the mailbox
  task automatic issueJob(input int srcW, input int dstW, input int blocks);
    hostWrite(sortPkg::srcWord, 32'(srcW * sortPkg::wordBytes));
    hostWrite(sortPkg::dstWord, 32'(dstW * sortPkg::wordBytes));
    cmdSent = 1'b1;
    hostWrite(sortPkg::cmdWord,
              (32'(blocks) << sortPkg::countLsb) | (32'h1 << sortPkg::goBit));
  endtask

  // waits for the status word to move on, then checks it
  task automatic waitJobDone(input bit nextQueued);
    logic [31:0] status;
    while (plbBramModel_inst.mbox[sortPkg::statusWord] == 32'(jobsDone))
      @(posedge CLK);
    #1;
    jobsDone++;
    status = plbBramModel_inst.mbox[sortPkg::statusWord];
    assert (status == 32'(jobsDone))
      else failNow($sformatf("status word is %0d, expected %0d", status, jobsDone));
    // a queued command keeps its go bit until the mailbox picks it up
    assert (nextQueued || !plbBramModel_inst.mbox[sortPkg::cmdWord][sortPkg::goBit])
      else failNow("go bit still set after the job ended");
  endtask

  task automatic checkJob(input int srcW, input int dstW, input int blocks);
    logic [sortPkg::dataWidth-1:0] refQ[$];
    logic [sortPkg::dataWidth-1:0] key;
    logic [sortPkg::dataWidth-1:0] got;
    int                            j;
    for (int b = 0; b < blocks; b++) begin
      refQ.delete();
      for (int k = 0; k < BlockSize; k++)
        refQ.push_back(memWord(srcW + b * BlockSize + k));
      // unsigned insertion sort of the source block
      for (int k = 1; k < BlockSize; k++) begin
        key = refQ[k];
        j   = k - 1;
        while (j >= 0 && refQ[j] > key) begin
          refQ[j+1] = refQ[j];
          j--;
        end
        refQ[j+1] = key;
      end
      for (int k = 0; k < BlockSize; k++) begin
        got = memWord(dstW + b * BlockSize + k);
        assert (k == 0 || memWord(dstW + b * BlockSize + k - 1) <= got)
          else failNow($sformatf("block %0d word %0d breaks ascending order", b, k));
        assert (got == refQ[k])
          else failNow($sformatf("block %0d word %0d is %h, expected %h",
                                 b, k, got, refQ[k]));
      end
    end
  endtask

  initial begin
    arstN      = 1'b0;
    hostWe     = 1'b0;
    hostAddr   = '0;
    hostData   = '0;
    slowWrites = 1'b0;
    cmdSent    = 1'b0;
    jobsDone   = 0;
    repeat (16) @(posedge CLK);
    #1;
    arstN = 1'b1;
    // idle stretch with the mailbox polling
    repeat (40) @(posedge CLK);

    // single block
    issueJob(0, 512, 1);
    waitJobDone(1'b0);
    checkJob(0, 512, 1);

    // long job under slow write acks
    slowWrites = 1'b1;
    issueJob(16, 528, 12);
    waitJobDone(1'b0);
    slowWrites = 1'b0;
    checkJob(16, 528, 12);

    // second command goes in once the first one is taken
    issueJob(128, 640, 3);
    while (plbBramModel_inst.mbox[sortPkg::cmdWord][sortPkg::goBit])
      @(posedge CLK);
    #1;
    issueJob(160, 672, 2);
    assert (plbBramModel_inst.mbox[sortPkg::statusWord] == 32'(jobsDone))
      else failNow("first back to back job finished before the second was queued");
    waitJobDone(1'b1);
    checkJob(128, 640, 3);
    waitJobDone(1'b0);
    checkJob(160, 672, 2);

    if (errorCount == 0)
      $display("All tests passed!");
    else
      $display("Test failures found");
    $finish;
  end

endmodule

// File: bench/plbBramModel.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// plb slave memory and mailbox block ram
// single beats, random acknowledge delays
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/100ps

module plbBramModel (
  input  logic                              CLK,
  input  logic                              mRequest,
  input  logic                              mRNW,
  input  logic [sortPkg::addrWidth-1:0]     mABus,
  input  logic [sortPkg::dataWidth-1:0]     mWrDBus,
  input  logic                              slowWrites,
  output logic                              mAddrAck,
  output logic                              mRdDAck,
  output logic                              mWrDAck,
  output logic [sortPkg::dataWidth-1:0]     mRdDBus,
  output logic                              mBusy,
  output logic                              mErr,
  input  logic                              bramCLK,
  input  logic                              bramRST,
  input  logic                              bramEN,
  input  logic [3:0]                        bramWEN,
  input  logic [sortPkg::addrWidth-1:0]     bramAddr,
  input  logic [31:0]                       bramDout,
  output logic [31:0]                       bramDin,
  input  logic                              hostWe,
  input  logic [sortPkg::bramAddrWidth-1:0] hostAddr,
  input  logic [31:0]                       hostData
);

  typedef enum logic [1:0] {Idle, AddrWait, DataWait, DataAck} slaveT;

  slaveT                         slaveState;
  int unsigned                   delay;
  // 1024 bus words, byte address bits 12:3
  logic [sortPkg::dataWidth-1:0] mem  [0:1023];
  logic [31:0]                   mbox [0:16383];

  assign mBusy = 1'b0;
  assign mErr  = 1'b0;

  initial begin
    // one seed for the fill and for every ack delay
    void'($urandom(32'hdea317c1));
    for (int i = 0; i < 1024; i++)
      mem[10'(i)] <= {$urandom, $urandom};
    for (int i = 0; i < 16384; i++)
      mbox[14'(i)] <= '0;
    slaveState <= Idle;
    mAddrAck   <= 1'b0;
    mRdDAck    <= 1'b0;
    mWrDAck    <= 1'b0;
    mRdDBus    <= '0;
    bramDin    <= '0;
  end

  // outputs settle 1 ns after the edge
  always @(posedge CLK) begin
    if (bramRST) begin
      slaveState <= Idle;
      mAddrAck   <= #1 1'b0;
      mRdDAck    <= #1 1'b0;
      mWrDAck    <= #1 1'b0;
    end else begin
      case (slaveState)
        Idle: begin
          if (mRequest) begin
            delay      <= $urandom_range(3, 0);
            slaveState <= AddrWait;
          end
        end
        AddrWait: begin
          if (delay == 0) begin
            mAddrAck   <= #1 1'b1;
            // stretched write data phase backs up the sorting pipeline
            delay      <= $urandom_range(3, 0) + ((slowWrites && !mRNW) ? 6 : 0);
            slaveState <= DataWait;
          end else begin
            delay <= delay - 1;
          end
        end
        // address and direction stay put until the data ack
        DataWait: begin
          mAddrAck <= #1 1'b0;
          if (delay == 0) begin
            if (mRNW) begin
              mRdDAck <= #1 1'b1;
              mRdDBus <= #1 mem[mABus[12:3]];
            end else begin
              mWrDAck           <= #1 1'b1;
              mem[mABus[12:3]]  <= mWrDBus;
            end
            slaveState <= DataAck;
          end else begin
            delay <= delay - 1;
          end
        end
        default: begin
          mRdDAck    <= #1 1'b0;
          mWrDAck    <= #1 1'b0;
          slaveState <= Idle;
        end
      endcase
    end
  end

  // mailbox ram, one cycle read latency, byte write enables
  always @(posedge bramCLK) begin
    if (bramEN) begin
      bramDin <= #1 mbox[bramAddr[15:2]];
      for (int b = 0; b < 4; b++)
        if (bramWEN[b])
          mbox[bramAddr[15:2]][8*b +: 8] <= bramDout[8*b +: 8];
    end
    // host side write lands last
    if (hostWe)
      mbox[hostAddr] <= hostData;
  end

endmodule

// File: verilog/sortTester.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// sort tester top level
// mailbox, plb engine, loader, odd-even stage
// array and writer wired together
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/100ps

module sortTester #(
  parameter int BlockSize = 8
) (
  input  logic                                  CLK,
  input  logic                                  arstN,
  // plb master outputs
  output logic [sortPkg::addrWidth-1:0]         mABus,
  output logic [sortPkg::dataWidth/8-1:0]       mBE,
  output logic                                  mRNW,
  output logic                                  mAbort,
  output logic                                  mBusLock,
  output logic                                  mCompress,
  output logic                                  mGuarded,
  output logic                                  mLockErr,
  output logic [1:0]                            mMSize,
  output logic                                  mOrdered,
  output logic [1:0]                            mPriority,
  output logic                                  mRdBurst,
  output logic                                  mRequest,
  output logic [3:0]                            mSize,
  output logic [2:0]                            mType,
  output logic                                  mWrBurst,
  output logic [sortPkg::dataWidth-1:0]         mWrDBus,
  // plb master inputs
  input  logic                                  mAddrAck,
  input  logic                                  mBusy,
  input  logic                                  mErr,
  input  logic                                  mRdDAck,
  input  logic [sortPkg::dataWidth-1:0]         mRdDBus,
  input  logic                                  mWrDAck,
  // mailbox block ram port
  output logic [sortPkg::addrWidth-1:0]         bramAddr,
  output logic [31:0]                           bramDout,
  output logic [3:0]                            bramWEN,
  output logic                                  bramEN,
  output logic                                  bramCLK,
  output logic                                  bramRST,
  input  logic [31:0]                           bramDin
);

  logic [sortPkg::bramAddrWidth-1:0] bramWordAddr;
  logic                              jobStart;
  logic                              jobDone;
  logic [sortPkg::addrWidth-1:0]     srcAddr;
  logic [sortPkg::addrWidth-1:0]     dstAddr;
  logic [sortPkg::countWidth-1:0]    blockCount;
  logic                              rdReq;
  logic                              rdDone;
  logic [sortPkg::addrWidth-1:0]     rdAddr;
  logic [sortPkg::dataWidth-1:0]     rdData;
  logic                              wrReq;
  logic                              wrDone;
  logic [sortPkg::addrWidth-1:0]     wrAddr;
  logic [sortPkg::dataWidth-1:0]     wrData;
  logic                              advance;
  // stage chain, index 0 is the loader, BlockSize the writer side
  logic [BlockSize:0]                                          stgValid;
  logic [BlockSize:0][BlockSize-1:0][sortPkg::dataWidth-1:0]   stgData;

  // byte address from the word address
  assign bramAddr = {{(sortPkg::addrWidth - sortPkg::bramAddrWidth - 2){1'b0}},
                     bramWordAddr, 2'b00};
  assign bramCLK  = CLK;
  assign bramRST  = ~arstN;

  // single beats only, no burst, lock or abort
  assign mAbort    = 1'b0;
  assign mBusLock  = 1'b0;
  assign mCompress = 1'b0;
  assign mGuarded  = 1'b0;
  assign mLockErr  = 1'b0;
  assign mMSize    = 2'b00;
  assign mOrdered  = 1'b0;
  assign mPriority = 2'b00;
  assign mRdBurst  = 1'b0;
  assign mSize     = 4'b0000;
  assign mType     = 3'b000;
  assign mWrBurst  = 1'b0;

  bramMailbox bramMailbox_inst (
    .CLK, .arstN, .bramDin, .jobDone, .bramWordAddr, .bramDout, .bramWEN, .bramEN,
    .jobStart, .srcAddr, .dstAddr, .blockCount
  );

  plbMasterEngine plbMasterEngine_inst (
    .CLK, .arstN, .rdReq, .rdAddr, .wrReq, .wrAddr, .wrData, .mAddrAck, .mRdDAck,
    .mRdDBus, .mWrDAck, .mErr, .rdDone, .rdData, .wrDone, .mRequest, .mABus, .mRNW,
    .mBE, .mWrDBus
  );

  blockLoader #(.BlockSize(BlockSize)) blockLoader_inst (
    .CLK, .arstN, .jobStart, .srcAddr, .blockCount, .rdDone, .rdData, .advance,
    .rdReq, .rdAddr, .loadValid(stgValid[0]), .loadData(stgData[0])
  );

  // alternating even and odd rows
  for (genvar i = 0; i < BlockSize; i++) begin : gStage
    oddEvenStage #(.BlockSize(BlockSize), .Parity(i % 2)) oddEvenStage_inst (
      .CLK, .arstN, .advance,
      .inValid(stgValid[i]), .inData(stgData[i]),
      .outValid(stgValid[i+1]), .outData(stgData[i+1])
    );
  end

  blockWriter #(.BlockSize(BlockSize)) blockWriter_inst (
    .CLK, .arstN, .jobStart, .dstAddr, .blockCount,
    .sortValid(stgValid[BlockSize]), .sortData(stgData[BlockSize]), .wrDone,
    .advance, .wrReq, .wrAddr, .wrData, .jobDone
  );

endmodule

// File: verilog/bramMailbox.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// block ram mailbox
// polls the command word, starts a job and posts
// the finished job count in the status word
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/100ps

module bramMailbox (
  input  logic                              CLK,
  input  logic                              arstN,
  input  logic [31:0]                       bramDin,
  input  logic                              jobDone,
  output logic [sortPkg::bramAddrWidth-1:0] bramWordAddr,
  output logic [31:0]                       bramDout,
  output logic [3:0]                        bramWEN,
  output logic                              bramEN,
  output logic                              jobStart,
  output logic [sortPkg::addrWidth-1:0]     srcAddr,
  output logic [sortPkg::addrWidth-1:0]     dstAddr,
  output logic [sortPkg::countWidth-1:0]    blockCount
);

  // each state names what the ram is doing during it
  typedef enum logic [2:0] {
    Poll, ReadCmd, CheckCmd, ReadSrc, ReadDst, ClearCmd, Busy, WriteStatus
  } stateT;

  stateT       state;
  logic [31:0] jobCount;

  always_ff @(posedge CLK or negedge arstN) begin
    if (!arstN) begin
      state        <= Poll;
      bramEN       <= 1'b0;
      bramWEN      <= 4'h0;
      bramWordAddr <= sortPkg::cmdWord;
      bramDout     <= '0;
      jobStart     <= 1'b0;
      jobCount     <= '0;
    end else begin
      jobStart <= 1'b0;
      case (state)
        Poll: begin
          bramEN       <= 1'b1;
          bramWordAddr <= sortPkg::cmdWord;
          state        <= ReadCmd;
        end
        ReadCmd: begin
          bramEN <= 1'b0;
          state  <= CheckCmd;
        end
        // command word on bramDin now
        CheckCmd: begin
          if (bramDin[sortPkg::goBit]) begin
            bramEN       <= 1'b1;
            bramWordAddr <= sortPkg::srcWord;
            state        <= ReadSrc;
          end else begin
            state <= Poll;
          end
        end
        // back to back reads, src data lands during ReadDst
        ReadSrc: begin
          bramWordAddr <= sortPkg::dstWord;
          state        <= ReadDst;
        end
        // clear the whole command word, dst data lands meanwhile
        ReadDst: begin
          bramWEN      <= 4'hf;
          bramWordAddr <= sortPkg::cmdWord;
          bramDout     <= '0;
          state        <= ClearCmd;
        end
        ClearCmd: begin
          bramEN   <= 1'b0;
          bramWEN  <= 4'h0;
          jobStart <= 1'b1;
          state    <= Busy;
        end
        // command word ignored until the writer finishes
        Busy: begin
          if (jobDone) begin
            jobCount     <= jobCount + 1'b1;
            bramEN       <= 1'b1;
            bramWEN      <= 4'hf;
            bramWordAddr <= sortPkg::statusWord;
            bramDout     <= jobCount + 1'b1;
            state        <= WriteStatus;
          end
        end
        default: begin
          bramEN  <= 1'b0;
          bramWEN <= 4'h0;
          state   <= Poll;
        end
      endcase
    end
  end

  // job parameters as they come off the ram
  always_ff @(posedge CLK) begin
    if (state == CheckCmd)
      blockCount <= bramDin[sortPkg::countLsb +: sortPkg::countWidth];
    if (state == ReadDst)
      srcAddr <= bramDin;
    if (state == ClearCmd)
      dstAddr <= bramDin;
  end

  // writer only finishes a job this mailbox started
  assert property (@(posedge CLK) disable iff (!arstN) jobDone |-> state == Busy);

endmodule

// File: verilog/plbMasterEngine.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// plb master engine
// one single-beat read or write at a time
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/100ps

module plbMasterEngine (
  input  logic                            CLK,
  input  logic                            arstN,
  input  logic                            rdReq,
  input  logic [sortPkg::addrWidth-1:0]   rdAddr,
  input  logic                            wrReq,
  input  logic [sortPkg::addrWidth-1:0]   wrAddr,
  input  logic [sortPkg::dataWidth-1:0]   wrData,
  input  logic                            mAddrAck,
  input  logic                            mRdDAck,
  input  logic [sortPkg::dataWidth-1:0]   mRdDBus,
  input  logic                            mWrDAck,
  input  logic                            mErr,
  output logic                            rdDone,
  output logic [sortPkg::dataWidth-1:0]   rdData,
  output logic                            wrDone,
  output logic                            mRequest,
  output logic [sortPkg::addrWidth-1:0]   mABus,
  output logic                            mRNW,
  output logic [sortPkg::dataWidth/8-1:0] mBE,
  output logic [sortPkg::dataWidth-1:0]   mWrDBus
);

  typedef enum logic [1:0] {Idle, Addr, Data} stateT;

  stateT state;
  logic  doneCycle;
  logic  startRd;
  logic  startWr;
  logic  dataAck;
  logic  finish;

  // requester still shows the old address while its done pulse is high
  assign doneCycle = rdDone || wrDone;
  // reads win
  assign startRd = rdReq && !doneCycle;
  assign startWr = wrReq && !rdReq && !doneCycle;
  assign dataAck = mRNW ? mRdDAck : mWrDAck;
  // data ack may come together with the address ack
  assign finish  = dataAck && (state == Data || (state == Addr && mAddrAck));

  always_ff @(posedge CLK or negedge arstN) begin
    if (!arstN) begin
      state    <= Idle;
      mRequest <= 1'b0;
      mRNW     <= 1'b0;
      mBE      <= '0;
      rdDone   <= 1'b0;
      wrDone   <= 1'b0;
    end else begin
      rdDone <= 1'b0;
      wrDone <= 1'b0;
      case (state)
        Idle: begin
          if (startRd || startWr) begin
            mRequest <= 1'b1;
            mRNW     <= startRd;
            mBE      <= '1;
            state    <= Addr;
          end
        end
        Addr: begin
          if (mAddrAck) begin
            mRequest <= 1'b0;
            state    <= Data;
          end
        end
        default: ;
      endcase
      // overrides the Data step above on a combined ack
      if (finish) begin
        rdDone <= mRNW;
        wrDone <= !mRNW;
        mBE    <= '0;
        state  <= Idle;
      end
    end
  end

  // address and write data follow the request while idle
  always_ff @(posedge CLK) begin
    if (state == Idle) begin
      mABus   <= startRd ? rdAddr : wrAddr;
      mWrDBus <= wrData;
    end
    if (finish && mRNW)
      rdData <= mRdDBus;
  end

  // loader and writer take turns, never both waiting
  assert property (@(posedge CLK) disable iff (!arstN) !(rdReq && wrReq));
  // no error path, the slave must never flag one
  assert property (@(posedge CLK) disable iff (!arstN) !mErr);

endmodule

// File: verilog/blockWriter.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// block writer
// buffers a sorted block, writes it out and
// signals the end of the job
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/100ps

module blockWriter #(
  parameter int BlockSize = 8
) (
  input  logic                                         CLK,
  input  logic                                         arstN,
  input  logic                                         jobStart,
  input  logic [sortPkg::addrWidth-1:0]                dstAddr,
  input  logic [sortPkg::countWidth-1:0]               blockCount,
  input  logic                                         sortValid,
  input  logic [BlockSize-1:0][sortPkg::dataWidth-1:0] sortData,
  input  logic                                         wrDone,
  output logic                                         advance,
  output logic                                         wrReq,
  output logic [sortPkg::addrWidth-1:0]                wrAddr,
  output logic [sortPkg::dataWidth-1:0]                wrData,
  output logic                                         jobDone
);

  localparam int                  IdxWidth = $clog2(BlockSize);
  localparam logic [IdxWidth-1:0] LastIdx  = IdxWidth'(BlockSize - 1);

  logic                                         bufFull;
  logic                                         capture;
  logic [BlockSize-1:0][sortPkg::dataWidth-1:0] buffer;
  logic [IdxWidth-1:0]                          wordIdx;
  logic [sortPkg::countWidth-1:0]               blocksLeft;

  // pipeline holds still while the buffer drains
  // which also keeps the loader off the bus
  assign advance = !bufFull;
  assign capture = sortValid && !bufFull;
  assign wrReq   = bufFull;
  assign wrData  = buffer[wordIdx];

  always_ff @(posedge CLK or negedge arstN) begin
    if (!arstN) begin
      bufFull    <= 1'b0;
      wordIdx    <= '0;
      blocksLeft <= '0;
      jobDone    <= 1'b0;
    end else begin
      // empty job ends at once
      jobDone <= jobStart && blockCount == '0;
      if (jobStart)
        blocksLeft <= blockCount;
      if (capture) begin
        bufFull <= 1'b1;
        wordIdx <= '0;
      end else if (wrDone) begin
        if (wordIdx == LastIdx) begin
          bufFull    <= 1'b0;
          blocksLeft <= blocksLeft - 1'b1;
          jobDone    <= blocksLeft == 1;
        end else begin
          wordIdx <= wordIdx + 1'b1;
        end
      end
    end
  end

  always_ff @(posedge CLK) begin
    if (capture)
      buffer <= sortData;
    if (jobStart)
      wrAddr <= dstAddr;
    else if (wrDone)
      wrAddr <= wrAddr + sortPkg::wordBytes;
  end

  // no more sorted blocks than the job asked the loader for
  assert property (@(posedge CLK) disable iff (!arstN) capture |-> blocksLeft != '0);

endmodule

// File: verilog/blockLoader.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// block loader
// fills a block from source memory word by word
// and offers it to the first sorting stage
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/100ps

module blockLoader #(
  parameter int BlockSize = 8
) (
  input  logic                                         CLK,
  input  logic                                         arstN,
  input  logic                                         jobStart,
  input  logic [sortPkg::addrWidth-1:0]                srcAddr,
  input  logic [sortPkg::countWidth-1:0]               blockCount,
  input  logic                                         rdDone,
  input  logic [sortPkg::dataWidth-1:0]                rdData,
  input  logic                                         advance,
  output logic                                         rdReq,
  output logic [sortPkg::addrWidth-1:0]                rdAddr,
  output logic                                         loadValid,
  output logic [BlockSize-1:0][sortPkg::dataWidth-1:0] loadData
);

  localparam int                  IdxWidth = $clog2(BlockSize);
  localparam logic [IdxWidth-1:0] LastIdx  = IdxWidth'(BlockSize - 1);

  logic [IdxWidth-1:0]            wordIdx;
  logic [sortPkg::countWidth-1:0] blocksLeft;
  logic                           rdPending;

  // advance low means the writer owns the bus, so hold off
  // an accepted read still completes, its rdDone is taken below
  assign rdReq = rdPending && advance;

  always_ff @(posedge CLK or negedge arstN) begin
    if (!arstN) begin
      rdPending  <= 1'b0;
      loadValid  <= 1'b0;
      wordIdx    <= '0;
      blocksLeft <= '0;
    end else if (jobStart) begin
      wordIdx    <= '0;
      blocksLeft <= blockCount;
      rdPending  <= blockCount != '0;
    end else if (loadValid) begin
      // stage 0 took the block on this edge
      if (advance) begin
        loadValid <= 1'b0;
        rdPending <= blocksLeft != '0;
      end
    end else if (rdDone) begin
      if (wordIdx == LastIdx) begin
        wordIdx    <= '0;
        rdPending  <= 1'b0;
        loadValid  <= 1'b1;
        blocksLeft <= blocksLeft - 1'b1;
      end else begin
        wordIdx <= wordIdx + 1'b1;
      end
    end
  end

  always_ff @(posedge CLK) begin
    if (jobStart) begin
      rdAddr <= srcAddr;
    end else if (rdDone) begin
      rdAddr            <= rdAddr + sortPkg::wordBytes;
      loadData[wordIdx] <= rdData;
    end
  end

endmodule

// File: verilog/oddEvenStage.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// odd-even transposition stage
// one registered row of compare-exchange cells
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/100ps

module oddEvenStage #(
  parameter int BlockSize = 8,
  // 0 pairs from word 0, 1 pairs from word 1
  parameter int Parity    = 0
) (
  input  logic                                         CLK,
  input  logic                                         arstN,
  input  logic                                         advance,
  input  logic                                         inValid,
  input  logic [BlockSize-1:0][sortPkg::dataWidth-1:0] inData,
  output logic                                         outValid,
  output logic [BlockSize-1:0][sortPkg::dataWidth-1:0] outData
);

  logic [BlockSize-1:0][sortPkg::dataWidth-1:0] swapped;

  // unpaired end words pass straight through
  always_comb begin
    swapped = inData;
    for (int k = Parity; k < BlockSize - 1; k += 2) begin
      // unsigned compare, smaller word goes low
      if (inData[k] > inData[k+1]) begin
        swapped[k]   = inData[k+1];
        swapped[k+1] = inData[k];
      end
    end
  end

  always_ff @(posedge CLK or negedge arstN) begin
    if (!arstN)
      outValid <= 1'b0;
    else if (advance)
      outValid <= inValid;
  end

  // whole chain freezes together
  always_ff @(posedge CLK) begin
    if (advance)
      outData <= swapped;
  end

endmodule

// File: verilog/sortPkg.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// sort tester shared constants
// bus widths, mailbox layout and command fields
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

package sortPkg;

  // plb data and address buses
  localparam int dataWidth = 64;
  localparam int addrWidth = 32;
  // bytes per bus word, the address step
  localparam int wordBytes = dataWidth / 8;

  // mailbox block ram, word addressed
  localparam int bramAddrWidth = 14;

  // mailbox word offsets
  localparam logic [bramAddrWidth-1:0] cmdWord    = 14'd0;
  localparam logic [bramAddrWidth-1:0] srcWord    = 14'd1;
  localparam logic [bramAddrWidth-1:0] dstWord    = 14'd2;
  localparam logic [bramAddrWidth-1:0] statusWord = 14'd3;

  // command word fields
  // go request
  localparam int goBit = 0;
  // number of blocks in the job
  localparam int countLsb   = 8;
  localparam int countWidth = 8;

endpackage
